/* icache_top.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_controller.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_mem_port.sv
verilog/icache_top.sv
sim/icache_top_chk.sv
sim/icache_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it.
# The exit status is non-zero unless the simulation reports a clean pass.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module icache_top_tb -f icache_top.f -o icache_top_sim

# A failing assertion stops the simulator, the search below decides
output=$(./obj_dir/icache_top_sim 2>&1) || true
echo "$output"

echo "$output" | grep -q 'All tests passed!'

/* sim/icache_top_tb.sv */
/*
 * Testbench for the two-way instruction cache
 * Wishbone slave memory with random wait states, a reference cache model,
 * directed miss, hit, replacement, kill and flush cases and a random run
 */
`default_nettype none

`include "icache_config.svh"

module icache_top_tb import icache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RAND_FETCHES = 200;
  // Four beats of up to five cycles each plus lookup, fill and ack
  localparam int REFILL_WORST = 28;
  localparam int WATCHDOG_CYCLES = (RAND_FETCHES + 30) * REFILL_WORST + 200;

  // Three lines that share set 4
  localparam addr_t LINE_A = 32'h0000_1040;
  localparam addr_t LINE_B = 32'h0000_2040;
  localparam addr_t LINE_C = 32'h0000_3040;

  logic  clk_i;
  logic  rst_ni;
  logic  if2icache_req_i;
  logic  if2icache_kill_i;
  addr_t if2icache_addr_i;
  logic  flush_i;
  logic  icache2if_ack_o;
  word_t icache2if_instr_o;
  logic  wb_cyc_o;
  logic  wb_stb_o;
  addr_t wb_adr_o;
  word_t wb_dat_i;
  logic  wb_ack_i;

  integer seed = 32'hd8ad9a90;
  int     error_count = 0;
  int     check_count = 0;
  int     ack_count = 0;
  int     wait_left = 0;
  int     cyc_cycles = 0;
  addr_t  bus_reads [$];
  addr_t  rand_addr [RAND_FETCHES];

  // Reference cache state, mru marks the most recently used way
  logic   model_valid [2][`ICACHE_SETS];
  tag_t   model_tag   [2][`ICACHE_SETS];
  way_t   model_mru   [`ICACHE_SETS];

  icache_top icache_top_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .if2icache_req_i   (if2icache_req_i),
    .if2icache_kill_i  (if2icache_kill_i),
    .if2icache_addr_i  (if2icache_addr_i),
    .flush_i           (flush_i),
    .icache2if_ack_o   (icache2if_ack_o),
    .icache2if_instr_o (icache2if_instr_o),
    .wb_cyc_o          (wb_cyc_o),
    .wb_stb_o          (wb_stb_o),
    .wb_adr_o          (wb_adr_o),
    .wb_dat_i          (wb_dat_i),
    .wb_ack_i          (wb_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Memory contents, the word address scrambled by a fixed constant
  function automatic word_t mem_word(input addr_t a);
    return ((a >> 2) * 32'h9e37_79b9) ^ 32'h5a3c_96e1;
  endfunction

  function automatic index_t line_index(input addr_t a);
    return a[`ICACHE_LINE_LSB +: `ICACHE_INDEX_W];
  endfunction

  function automatic tag_t line_tag(input addr_t a);
    return a[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
  endfunction

  // Hit flag, way gives the hit way or else the victim
  function automatic logic predict_lookup(input addr_t a, output way_t way);
    index_t idx;
    logic   hit;
    idx = line_index(a);
    hit = 1'b0;
    // Empty way first, else the one not used last
    way = ~model_mru[idx];
    if (!model_valid[1][idx]) way = 1'b1;
    if (!model_valid[0][idx]) way = 1'b0;
    if (model_valid[1][idx] && model_tag[1][idx] == line_tag(a)) begin
      hit = 1'b1;
      way = 1'b1;
    end
    if (model_valid[0][idx] && model_tag[0][idx] == line_tag(a)) begin
      hit = 1'b1;
      way = 1'b0;
    end
    return hit;
  endfunction

  // Fill on a miss, the accessed way becomes most recent
  function automatic void record_access(input addr_t a);
    way_t way;
    if (!predict_lookup(a, way)) begin
      model_valid[way][line_index(a)] = 1'b1;
      model_tag[way][line_index(a)]   = line_tag(a);
    end
    model_mru[line_index(a)] = way;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Every fetch ack carries the word of the held address
  always @(negedge clk_i) begin
    if (rst_ni && icache2if_ack_o) begin
      ack_count++;
      check_value("icache2if_instr_o", icache2if_instr_o, mem_word(if2icache_addr_i));
    end
  end

  // Bus activity log
  always @(negedge clk_i) begin
    if (wb_cyc_o) begin
      cyc_cycles++;
    end
    if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
      bus_reads.push_back(wb_adr_o);
    end
  end

  // Wishbone slave, decides at the falling edge and answers on the rising edge
  always begin : wb_slave
    logic  pending;
    addr_t adr;
    @(negedge clk_i);
    // A killed refill gets no further ack
    pending = wb_cyc_o && wb_stb_o && !wb_ack_i && !if2icache_kill_i;
    adr     = wb_adr_o;
    @(posedge clk_i);
    if (pending && wait_left == 0) begin
      wb_ack_i  <= 1'b1;
      wb_dat_i  <= mem_word(adr);
      wait_left = $unsigned($random(seed)) % 4;
    end else begin
      wb_ack_i <= 1'b0;
      if (pending) wait_left--;
    end
  end

  // One fetch, hit latency and line reads compared with the model
  task automatic fetch(input addr_t a);
    way_t way;
    logic exp_hit;
    int   latency;
    int   reads_before;
    int   cyc_before;
    exp_hit      = predict_lookup(a, way);
    reads_before = bus_reads.size();
    cyc_before   = cyc_cycles;
    @(posedge clk_i);
    if2icache_req_i  <= 1'b1;
    if2icache_addr_i <= a;
    latency = 0;
    @(negedge clk_i);
    while (!icache2if_ack_o) begin
      latency++;
      @(negedge clk_i);
    end
    if (exp_hit) begin
      check_value("hit ack latency", latency, 1);
      check_value("wb_cyc_o cycles on hit", cyc_cycles - cyc_before, 0);
    end else begin
      check_value("wb read count", bus_reads.size() - reads_before, `ICACHE_LINE_WORDS);
      for (int i = 0; i < bus_reads.size() - reads_before; i++) begin
        check_value("wb_adr_o", bus_reads[reads_before + i],
                    (a & ~addr_t'(`ICACHE_LINE_WORDS * 4 - 1)) + addr_t'(4 * i));
      end
    end
    record_access(a);
    @(posedge clk_i);
    if2icache_req_i <= 1'b0;
  endtask

  // Missing fetch killed after its first word, the victim stays invalid
  task automatic fetch_killed(input addr_t a);
    way_t way;
    int   acks_before;
    acks_before = ack_count;
    // Victim of the refill that gets killed
    void'(predict_lookup(a, way));
    @(posedge clk_i);
    if2icache_req_i  <= 1'b1;
    if2icache_addr_i <= a;
    @(negedge clk_i);
    while (!(wb_cyc_o && wb_ack_i)) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    if2icache_req_i  <= 1'b0;
    if2icache_kill_i <= 1'b1;
    @(posedge clk_i);
    if2icache_kill_i <= 1'b0;
    @(negedge clk_i);
    check_value("wb_cyc_o after kill", 32'(wb_cyc_o), 0);
    repeat (REFILL_WORST) @(negedge clk_i);
    check_value("fetch acks after kill", ack_count - acks_before, 0);
    model_valid[way][line_index(a)] = 1'b0;
  endtask

  task automatic flush_cache();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    model_valid = '{default: 1'b0};
  endtask

  initial begin
    rst_ni           <= 1'b0;
    if2icache_req_i  <= 1'b0;
    if2icache_kill_i <= 1'b0;
    if2icache_addr_i <= '0;
    flush_i          <= 1'b0;
    wb_ack_i         <= 1'b0;
    wb_dat_i         <= '0;
    model_valid = '{default: 1'b0};
    model_mru   = '{default: 1'b0};
    // 128 words, four tags per set, drawn before the clock runs
    for (int i = 0; i < RAND_FETCHES; i++) begin
      rand_addr[i] = 32'h0000_8000 + addr_t'(($unsigned($random(seed)) % 128) * 4);
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Cold miss in the middle of A, then the rest of the line hits
    fetch(LINE_A + 8);
    fetch(LINE_A);
    fetch(LINE_A + 4);
    fetch(LINE_A + 12);
    // A and B both resident, touching A makes B the victim of C
    fetch(LINE_B + 4);
    fetch(LINE_A);
    fetch(LINE_C);
    fetch(LINE_A + 4);
    fetch(LINE_B);
    // Kill of a refill of C, the way of A is lost with it
    fetch_killed(LINE_C + 8);
    fetch(LINE_C + 8);
    fetch(LINE_A);
    // fence.i drops every line
    flush_cache();
    fetch(LINE_C);
    fetch(LINE_A);
    // Random fetches with random wait states
    for (int i = 0; i < RAND_FETCHES; i++) begin
      fetch(rand_addr[i]);
    end

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Bound from the number of fetches and the slowest refill
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the cache stopped answering",
             WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/icache_top_chk.sv */
/*
 * Instruction cache handshake checker
 * Bound into the cache top level, watches the fetch ack pulse
 * and the Wishbone classic request rules
 */
`default_nettype none

`include "icache_config.svh"

module icache_top_chk import icache_pkg::*; (
  input wire        clk_i,
  input wire        rst_ni,
  input wire        if2icache_req_i,
  input wire        icache2if_ack_o,
  input wire        wb_cyc_o,
  input wire        wb_stb_o,
  input wire addr_t wb_adr_o,
  input wire        wb_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Fetch ack is a single cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache2if_ack_o |=> !icache2if_ack_o)
    else $error("fetch ack held high for two cycles");

  // Strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o)
    else $error("wb_stb_o high without wb_cyc_o");

  // Address holds while the slave inserts wait states, an abort may drop stb
  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i) |=> (!wb_stb_o || $stable(wb_adr_o)))
    else $error("wb_adr_o changed while waiting for wb_ack_i");

  // Ack only while fetch holds its request
  ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache2if_ack_o |-> if2icache_req_i)
    else $error("fetch ack without a pending request");

endmodule

bind icache_top icache_top_chk u_icache_top_chk (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .if2icache_req_i (if2icache_req_i),
  .icache2if_ack_o (icache2if_ack_o),
  .wb_cyc_o        (wb_cyc_o),
  .wb_stb_o        (wb_stb_o),
  .wb_adr_o        (wb_adr_o),
  .wb_ack_i        (wb_ack_i)
);

`default_nettype wire

/* verilog/icache_top.sv */
/*
 * Two-way set-associative instruction cache
 * Fetch interface on one side, Wishbone classic line refill on the other
 */
`default_nettype none

`include "icache_config.svh"

module icache_top import icache_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,

  // Fetch stage
  input  wire        if2icache_req_i,
  input  wire        if2icache_kill_i,
  input  wire addr_t if2icache_addr_i,
  input  wire        flush_i,
  output logic       icache2if_ack_o,
  output word_t      icache2if_instr_o,

  // Instruction memory, Wishbone classic
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output addr_t      wb_adr_o,
  input  wire word_t wb_dat_i,
  input  wire        wb_ack_i
);

  // Tag array to controller
  logic    hit;
  way_t    hit_way;
  way_t    victim_way;

  // Controller to datapath
  way_t    read_way;
  logic    refill_start;
  logic    refill_abort;
  logic    tag_write;
  logic    invalidate;
  logic    lru_touch;
  logic    flush_all;
  way_t    fill_way;

  // Memory port beats
  logic    beat_valid;
  offset_t beat_offset;
  word_t   beat_data;
  logic    line_done;

  icache_controller u_controller (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .if2icache_req_i  (if2icache_req_i),
    .if2icache_kill_i (if2icache_kill_i),
    .if2icache_addr_i (if2icache_addr_i),
    .flush_i          (flush_i),
    .icache2if_ack_o  (icache2if_ack_o),
    .hit_i            (hit),
    .hit_way_i        (hit_way),
    .victim_way_i     (victim_way),
    .line_done_i      (line_done),
    .read_way_o       (read_way),
    .refill_start_o   (refill_start),
    .refill_abort_o   (refill_abort),
    .tag_write_o      (tag_write),
    .invalidate_o     (invalidate),
    .lru_touch_o      (lru_touch),
    .flush_all_o      (flush_all),
    .fill_way_o       (fill_way)
  );

  icache_tag_array u_tag_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_i       (if2icache_addr_i),
    .tag_write_i  (tag_write),
    .invalidate_i (invalidate),
    .fill_way_i   (fill_way),
    .lru_touch_i  (lru_touch),
    .touch_way_i  (read_way),
    .flush_all_i  (flush_all),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  // Beat index taken from the bus address of the word being read
  icache_data_array u_data_array (
    .clk_i          (clk_i),
    .write_i        (beat_valid),
    .write_way_i    (fill_way),
    .write_index_i  (wb_adr_o[`ICACHE_LINE_LSB +: `ICACHE_INDEX_W]),
    .write_offset_i (beat_offset),
    .write_data_i   (beat_data),
    .read_way_i     (read_way),
    .read_addr_i    (if2icache_addr_i),
    .read_data_o    (icache2if_instr_o)
  );

  icache_mem_port u_mem_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (refill_start),
    .abort_i       (refill_abort),
    .line_addr_i   (if2icache_addr_i),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_ack_i      (wb_ack_i),
    .wb_dat_i      (wb_dat_i),
    .beat_valid_o  (beat_valid),
    .beat_offset_o (beat_offset),
    .beat_data_o   (beat_data),
    .line_done_o   (line_done)
  );

endmodule

`default_nettype wire

/* verilog/icache_mem_port.sv */
/*
 * Instruction cache memory port
 * Wishbone classic master reading one line as single word reads
 * Hands each word to the data store, releases the bus on abort
 */
`default_nettype none

`include "icache_config.svh"

module icache_mem_port import icache_pkg::*; (
  input  wire          clk_i,
  input  wire          rst_ni,

  // Controller side
  input  wire          start_i,
  input  wire          abort_i,
  input  wire addr_t   line_addr_i,

  // Wishbone classic master
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output addr_t        wb_adr_o,
  input  wire          wb_ack_i,
  input  wire word_t   wb_dat_i,

  // Beats into the data store
  output logic         beat_valid_o,
  output offset_t      beat_offset_o,
  output word_t        beat_data_o,
  output logic         line_done_o
);

  logic                                       busy_q;
  offset_t                                    cnt_q;
  logic [`ICACHE_ADDR_W-`ICACHE_LINE_LSB-1:0] line_q;

  // stb stays up until each ack, next word follows straight after
  assign wb_cyc_o = busy_q;
  assign wb_stb_o = busy_q;
  assign wb_adr_o = {line_q, cnt_q, {`ICACHE_BYTE_OFF_W{1'b0}}};

  // Beat dropped when the refill is aborted in the same cycle
  assign beat_valid_o  = busy_q & wb_ack_i & ~abort_i;
  assign beat_offset_o = cnt_q;
  assign beat_data_o   = wb_dat_i;
  assign line_done_o   = beat_valid_o & (cnt_q == offset_t'(`ICACHE_LINE_WORDS - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni || abort_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (beat_valid_o) begin
      // Word counter wraps to zero after the last word
      cnt_q <= cnt_q + 1'b1;
      if (line_done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Line aligned base address
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      line_q <= line_addr_i[`ICACHE_ADDR_W-1:`ICACHE_LINE_LSB];
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_data_array.sv */
/*
 * Instruction cache data store
 * Line words of both ways, one word write port and a registered word read
 */
`default_nettype none

`include "icache_config.svh"

module icache_data_array import icache_pkg::*; (
  input  wire          clk_i,

  // Refill write port
  input  wire          write_i,
  input  wire way_t    write_way_i,
  input  wire index_t  write_index_i,
  input  wire offset_t write_offset_i,
  input  wire word_t   write_data_i,

  // Fetch read port
  input  wire way_t    read_way_i,
  input  wire addr_t   read_addr_i,
  output word_t        read_data_o
);

  word_t   line_mem [2][`ICACHE_SETS][`ICACHE_LINE_WORDS];

  index_t  read_index;
  offset_t read_offset;

  assign read_index  = read_addr_i[`ICACHE_LINE_LSB +: `ICACHE_INDEX_W];
  assign read_offset = read_addr_i[`ICACHE_BYTE_OFF_W +: `ICACHE_OFFSET_W];

  // One beat per cycle during refill
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      line_mem[write_way_i][write_index_i][write_offset_i] <= write_data_i;
    end
  end

  // Registered read, valid in the cycle of the fetch ack
  always_ff @(posedge clk_i) begin
    read_data_o <= line_mem[read_way_i][read_index][read_offset];
  end

endmodule

`default_nettype wire

/* verilog/icache_tag_array.sv */
/*
 * Instruction cache tag store
 * Valid bits, tags and a one-bit LRU per set for two ways
 * Gives hit, hit way and the replacement victim for the addressed set
 */
`default_nettype none

`include "icache_config.svh"

module icache_tag_array import icache_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,

  input  wire addr_t addr_i,
  input  wire        tag_write_i,
  input  wire        invalidate_i,
  input  wire way_t  fill_way_i,
  input  wire        lru_touch_i,
  input  wire way_t  touch_way_i,
  input  wire        flush_all_i,

  output logic       hit_o,
  output way_t       hit_way_o,
  output way_t       victim_way_o
);

  logic [`ICACHE_SETS-1:0] valid_q [2];
  tag_t                    tag_q   [2][`ICACHE_SETS];
  // Most recently used way of each set
  way_t [`ICACHE_SETS-1:0] mru_q;

  index_t index;
  tag_t   tag;
  logic   match0;
  logic   match1;

  assign index = addr_i[`ICACHE_LINE_LSB +: `ICACHE_INDEX_W];
  assign tag   = addr_i[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];

  // Tag compare qualified by valid
  assign match0 = valid_q[0][index] & (tag_q[0][index] == tag);
  assign match1 = valid_q[1][index] & (tag_q[1][index] == tag);

  assign hit_o     = match0 | match1;
  assign hit_way_o = match1;

  // Empty way first, else the one not used most recently
  always_comb begin
    if (!valid_q[0][index]) begin
      victim_way_o = 1'b0;
    end else if (!valid_q[1][index]) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = ~mru_q[index];
    end
  end

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_all_i) begin
      valid_q <= '{default: '0};
    end else if (tag_write_i) begin
      valid_q[fill_way_i][index] <= 1'b1;
    end else if (invalidate_i) begin
      valid_q[fill_way_i][index] <= 1'b0;
    end
  end

  // Tags
  always_ff @(posedge clk_i) begin
    if (tag_write_i) begin
      tag_q[fill_way_i][index] <= tag;
    end
  end

  // LRU, all sets start with way 0
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mru_q <= '0;
    end else if (lru_touch_i) begin
      mru_q[index] <= touch_way_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_controller.sv */
/*
 * Instruction cache controller
 * FSM for lookup, line refill, kill and flush
 * Drives the fetch ack, the memory port request and the tag array updates
 */
`default_nettype none

`include "icache_config.svh"

module icache_controller import icache_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_ni,

  // Fetch side
  input  wire            if2icache_req_i,
  input  wire            if2icache_kill_i,
  input  wire addr_t     if2icache_addr_i,
  input  wire            flush_i,
  output logic           icache2if_ack_o,

  // Tag array status
  input  wire            hit_i,
  input  wire way_t      hit_way_i,
  input  wire way_t      victim_way_i,

  // Memory port status
  input  wire            line_done_i,

  // Datapath control
  output way_t           read_way_o,
  output logic           refill_start_o,
  output logic           refill_abort_o,
  output logic           tag_write_o,
  output logic           invalidate_o,
  output logic           lru_touch_o,
  output logic           flush_all_o,
  output way_t           fill_way_o
);

  icache_state_e                          state_ff, state_next;
  logic                                   lookup;
  logic                                   ack_next;
  way_t                                   fill_way_ff;

  // One lookup per request, skipped in the ack cycle while fetch still holds the address
  assign lookup = (state_ff == ICACHE_IDLE) & if2icache_req_i & ~icache2if_ack_o &
                  ~if2icache_kill_i & ~flush_i;

  // Victim straight from the tag array when the miss is seen, latched afterwards
  assign fill_way_o = (state_ff == ICACHE_IDLE) ? victim_way_i : fill_way_ff;

  // Hit way for reads in IDLE, fill way when the LRU is touched after a fill
  assign read_way_o = (state_ff == ICACHE_IDLE) ? hit_way_i : fill_way_ff;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_ff <= ICACHE_IDLE;
    end else begin
      state_ff <= state_next;
    end
  end

  // Remember victim of the miss
  always_ff @(posedge clk_i) begin
    if (refill_start_o) begin
      fill_way_ff <= victim_way_i;
    end
  end

  always_comb begin
    state_next     = state_ff;
    ack_next       = 1'b0;
    refill_start_o = 1'b0;
    refill_abort_o = 1'b0;
    tag_write_o    = 1'b0;
    invalidate_o   = 1'b0;
    lru_touch_o    = 1'b0;
    flush_all_o    = 1'b0;

    unique case (state_ff)
      ICACHE_IDLE: begin
        if (flush_i) begin
          flush_all_o = 1'b1;
        end else if (lookup && hit_i) begin
          // Registered ack, data array read lines up with it
          ack_next    = 1'b1;
          lru_touch_o = 1'b1;
        end else if (lookup) begin
          // Victim goes invalid now so a killed refill leaves no stale line
          refill_start_o = 1'b1;
          invalidate_o   = 1'b1;
          state_next     = ICACHE_REFILL;
        end
      end

      ICACHE_REFILL: begin
        if (line_done_i) begin
          state_next = ICACHE_FILL_DONE;
        end
      end

      ICACHE_FILL_DONE: begin
        // Line complete, tag and valid written, fill way becomes most recent
        tag_write_o = 1'b1;
        lru_touch_o = 1'b1;
        state_next  = ICACHE_IDLE;
      end

      default: begin
        state_next = ICACHE_IDLE;
      end
    endcase

    // Kill from fetch wins over every state
    if (if2icache_kill_i) begin
      state_next     = ICACHE_IDLE;
      refill_abort_o = (state_ff == ICACHE_REFILL);
      ack_next       = 1'b0;
      refill_start_o = 1'b0;
      invalidate_o   = 1'b0;
      tag_write_o    = 1'b0;
      lru_touch_o    = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      icache2if_ack_o <= 1'b0;
    end else begin
      icache2if_ack_o <= ack_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
/*
 * Instruction cache package
 * Vector types for addresses and fields, and the controller state encoding
 */
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

  // Byte address and instruction word
  typedef logic [`ICACHE_ADDR_W-1:0]   addr_t;
  typedef logic [`ICACHE_WORD_W-1:0]   word_t;

  // Address fields
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

  // Way select, 0 or 1
  typedef logic                        way_t;

  // Controller states
  typedef enum logic [1:0] {
    ICACHE_IDLE,
    ICACHE_REFILL,
    ICACHE_FILL_DONE
  } icache_state_e;

endpackage

`default_nettype wire

/* verilog/icache_config.svh */
/*
 * Instruction cache configuration
 * Address and word widths, set count, line size and derived field widths
 */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Byte address and instruction word widths
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// Geometry, two ways are fixed by the one-bit LRU
`define ICACHE_SETS        8
`define ICACHE_LINE_WORDS  4

// Derived field widths of a fetch address
`define ICACHE_BYTE_OFF_W  2
`define ICACHE_OFFSET_W    $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_INDEX_W     $clog2(`ICACHE_SETS)
`define ICACHE_LINE_LSB    (`ICACHE_BYTE_OFF_W + `ICACHE_OFFSET_W)
`define ICACHE_TAG_LSB     (`ICACHE_LINE_LSB + `ICACHE_INDEX_W)
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_TAG_LSB)

`endif
